//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f sources.f

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_decode_top.sv
// decode front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    localparam int BUF_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_WORDS     = 50;                        // words over all tests
    localparam int N_STALL     = 20 + 3 * 12;               // hold window plus slow release
    localparam int LIMIT       = 16 + N_WORDS * 12 + N_STALL * 2 + 200;
    localparam int RET_AUTO    = 0;                         // credit back per insn
    localparam int RET_HOLD    = 1;                         // keep every credit
    localparam int RET_SLOW    = 2;                         // one credit per 3 cycles

    logic                 clk;
    logic                 rst_n;
    logic                 pe;
    logic                 word_valid;
    besm_pkg::word_t      word;
    logic                 word_credit;
    logic                 mod_wr;
    besm_pkg::modidx_t    mod_idx;
    besm_pkg::eaddr_t     mod_data;
    logic                 insn_valid;
    besm_pkg::insn_t      insn;
    logic                 insn_credit = 1'b0;

    besm_pkg::insn_t      got [$];                          // filled by the monitor only
    besm_pkg::insn_t      exp [$];                          // filled by the sender only
    besm_pkg::eaddr_t     mod_model [16];
    logic [31:0]          lfsr = 32'h7171178b;
    int                   credit_total = 0;                 // word_credit pulses seen
    int                   words_sent = 0;
    int                   chk_idx = 0;
    int                   owed = 0;                         // insns not yet credited
    int                   slow_cnt = 0;
    int                   ret_mode = RET_AUTO;
    int                   cycles = 0;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    decode_top #(.BUF_DEPTH(BUF_DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_decode_top (
        .clk, .rst_n, .pe, .word_valid, .word, .word_credit,
        .mod_wr, .mod_idx, .mod_data, .insn_valid, .insn, .insn_credit
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // monitor and downstream credit return
    always @(posedge clk) begin
        logic give;
        if (rst_n) begin
            if (insn_valid) begin
                got.push_back(insn);
                owed++;
            end
            if (word_credit)
                credit_total++;
        end
        slow_cnt = (slow_cnt + 1) % 3;
        give = (owed > 0) && (ret_mode == RET_AUTO || (ret_mode == RET_SLOW && slow_cnt == 0));
        if (give)
            owed--;
        #1 insn_credit = give;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, pipeline stopped delivering", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // reference decode and modify of one half plus its modifier update
    function automatic besm_pkg::insn_t model_half(input besm_pkg::word_t w, input logic pe_m,
                                                   input logic right);
        besm_pkg::insn_t  r;
        logic [31:0]      h;       // native half
        besm_pkg::word_t  s;       // besm6 half moved to right position
        besm_pkg::eaddr_t base;
        h       = right ? w[32:1] : w[64:33];
        s       = right ? w : (w >> 24);
        r.extop = 1'b0;
        if (!pe_m) begin
            r.ir = h[31:28];
            r.op = h[27:20];
            base = h[14:0];
            if (h[27:20] == 8'h3f) begin   // escape puts opcode in next byte
                r.extop = 1'b1;
                r.op    = h[19:12];
            end
        end else begin
            r.ir = right ? w[36:33] : {w[64], w[59:57]};
            if (s[32]) begin
                r.op = {s[32:28], 3'd0};
                base = s[27:13];                       // long format zero extended
            end else begin
                r.op = {2'b00, s[30:25]};
                base = {{3{s[31]}}, s[24:13]};         // short format sign extended
            end
        end
        r.eaddr = base + mod_model[r.ir];
        if (r.ir == 4'd15)
            mod_model[15] = mod_model[15] + 1'b1;      // stack post-increment
        return r;
    endfunction

    task automatic send_word(input besm_pkg::word_t w);
        while (BUF_DEPTH + credit_total - words_sent <= 0) begin
            @(posedge clk);
            #1;
        end
        word_valid = 1'b1;
        word       = w;
        words_sent++;
        exp.push_back(model_half(w, pe, 1'b0));      // left goes first
        exp.push_back(model_half(w, pe, 1'b1));
        @(posedge clk);
        #1;
        word_valid = 1'b0;
    endtask

    task automatic write_mod(input besm_pkg::modidx_t idx, input besm_pkg::eaddr_t data);
        mod_wr   = 1'b1;
        mod_idx  = idx;
        mod_data = data;
        if (idx != 4'd0)
            mod_model[idx] = data;                     // index 0 stays zero
        @(posedge clk);
        #1;
        mod_wr = 1'b0;
    endtask

    // wait for the pipeline to drain and compare in order
    task automatic check_outputs();
        while (got.size() < exp.size()) begin
            @(posedge clk);
            #1;
        end
        repeat (6) @(posedge clk);
        #1;
        if (got.size() != exp.size()) begin
            $display("instruction count mismatch: received %0d, expected %0d",
                     got.size(), exp.size());
            errors++;
        end
        while (chk_idx < exp.size() && chk_idx < got.size()) begin
            if (got[chk_idx] !== exp[chk_idx]) begin
                $display("FAIL insn[%0d] got %h expected %h", chk_idx, got[chk_idx],
                         exp[chk_idx]);
                errors++;
            end
            chk_idx++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%-18s passed", name);
        end else begin
            $display("%-18s %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    task automatic test_native_random();
        int              e0;
        besm_pkg::word_t w;
        e0 = errors;
        pe = 1'b0;
        for (int i = 0; i < 20; i++) begin
            w = lfsr_bits(64);
            if (w[60:53] == 8'h3f)
                w[53] = 1'b0;                          // keep clear of the escape
            if (w[28:21] == 8'h3f)
                w[21] = 1'b0;
            send_word(w);
        end
        check_outputs();
        report_test("native_random", e0);
    endtask

    task automatic test_extended_opcode();
        int              e0;
        besm_pkg::word_t w [4];
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            w[i]         = lfsr_bits(64);
            w[i][60:53]  = 8'h3f;
            w[i][28:21]  = 8'h3f;
        end
        pe = 1'b0;
        foreach (w[i]) send_word(w[i]);
        check_outputs();
        pe = 1'b1;                                     // same words without the escape
        foreach (w[i]) send_word(w[i]);
        check_outputs();
        report_test("extended_opcode", e0);
    endtask

    task automatic test_pe_formats();
        int              e0;
        besm_pkg::word_t w;
        e0 = errors;
        pe = 1'b1;
        for (int i = 0; i < 6; i++) begin
            w     = lfsr_bits(64);
            w[56] = (i < 3);                           // long format first
            w[32] = (i < 3);
            if (i >= 3) begin
                w[55] = i[0];                          // both signs on the short halves
                w[31] = !i[0];
            end
            send_word(w);
        end
        check_outputs();
        report_test("pe_formats", e0);
    endtask

    task automatic test_modifier_add();
        int              e0;
        besm_pkg::word_t w;
        e0 = errors;
        pe = 1'b0;
        for (int i = 1; i < 6; i++)
            write_mod(besm_pkg::modidx_t'(i), besm_pkg::eaddr_t'(lfsr_bits(15)));
        write_mod(4'd0, 15'h1234);                     // must be ignored
        for (int i = 0; i < 6; i++) begin
            w         = lfsr_bits(64);
            w[64:61]  = besm_pkg::modidx_t'(i);
            w[32:29]  = besm_pkg::modidx_t'(5 - i);
            send_word(w);
        end
        check_outputs();
        report_test("modifier_add", e0);
    endtask

    task automatic test_stack_mode();
        int              e0;
        besm_pkg::word_t w;
        e0 = errors;
        pe = 1'b0;
        write_mod(4'd15, 15'h7ffd);                    // wraps during the run
        for (int i = 0; i < 4; i++) begin
            w         = lfsr_bits(64);
            w[64:61]  = 4'hf;
            w[32:29]  = 4'hf;
            send_word(w);
        end
        check_outputs();
        report_test("stack_mode", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        int base;
        int pulses0;
        e0       = errors;
        base     = got.size();
        pulses0  = credit_total;
        ret_mode = RET_HOLD;
        for (int i = 0; i < 6; i++)
            send_word(lfsr_bits(64));
        while (got.size() < base + OUT_CREDITS) begin
            @(posedge clk);
            #1;
        end
        repeat (20) @(posedge clk);
        #1;
        if (got.size() - base != OUT_CREDITS) begin
            $display("FAIL insn_valid count got %h expected %h", got.size() - base, OUT_CREDITS);
            errors++;
        end
        ret_mode = RET_SLOW;
        check_outputs();
        if (credit_total - pulses0 != 6) begin
            $display("FAIL word_credit pulses got %h expected %h", credit_total - pulses0, 6);
            errors++;
        end
        report_test("back_pressure", e0);
    endtask

    initial begin
        rst_n      = 1'b0;
        pe         = 1'b0;
        word_valid = 1'b0;
        word       = '0;
        mod_wr     = 1'b0;
        mod_idx    = '0;
        mod_data   = '0;
        for (int i = 0; i < 16; i++)
            mod_model[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_native_random();
        test_extended_opcode();
        test_pe_formats();
        test_modifier_add();
        test_stack_mode();
        test_back_pressure();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/besm_pkg.sv
// micro-besm front end types
`default_nettype none

package besm_pkg;

    // field widths
    typedef logic [64:1] word_t;     // two instructions, left half in the upper bits
    typedef logic [3:0]  modidx_t;   // modifier register index
    typedef logic [7:0]  opcode_t;
    typedef logic [19:0] addr_t;     // raw address field
    typedef logic [14:0] eaddr_t;    // machine address space

    localparam modidx_t STACK_MOD  = 4'd15;   // stack pointer modifier
    localparam opcode_t EXT_ESCAPE = 8'h3f;   // base opcode of extended form

    // decode stage result, one per half
    typedef struct packed {
        modidx_t ir;
        opcode_t op;
        logic    extop;
        logic    ir15;     // stack mode
        addr_t   addr;
    } decoded_t;

    // subsystem output
    typedef struct packed {
        opcode_t op;
        logic    extop;
        modidx_t ir;
        eaddr_t  eaddr;    // address after modification
    } insn_t;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
// two-half decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  pe,          // besm6 compatibility
    input  wire                  head_valid,
    input  wire besm_pkg::word_t head_word,
    output logic                 pop,         // whole word consumed
    output logic                 dec_valid,
    output besm_pkg::decoded_t   dec,
    input  wire                  dec_ready
);

    typedef enum logic {
        HALF_LEFT,
        HALF_RIGHT
    } half_e;

    half_e              half;        // which half goes next
    logic               tkk;
    logic               load;        // stage register takes a half
    besm_pkg::decoded_t dec_next;
    besm_pkg::modidx_t  d_ir;
    besm_pkg::opcode_t  d_op;
    logic               d_extop;
    logic               d_ir15;
    besm_pkg::addr_t    d_addr;

    assign tkk = (half == HALF_RIGHT);

    decoder u_decoder (
        .dc    (head_word),
        .pe    (pe),
        .tkk   (tkk),
        .ir    (d_ir),
        .op    (d_op),
        .extop (d_extop),
        .ir15  (d_ir15),
        .addr  (d_addr)
    );

    always_comb begin
        dec_next.ir    = d_ir;
        dec_next.op    = d_op;
        dec_next.extop = d_extop;
        dec_next.ir15  = d_ir15;
        dec_next.addr  = d_addr;
    end

    // register empty or draining this cycle
    assign load = head_valid && (!dec_valid || dec_ready);
    assign pop  = load && tkk;     // right half done so release the word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half      <= HALF_LEFT;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= load || (dec_valid && !dec_ready);
            if (load)
                half <= tkk ? HALF_LEFT : HALF_RIGHT;
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            dec <= dec_next;
    end

endmodule

`default_nettype wire

//--- design/decode_top.sv
// micro-besm decode front end
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
    parameter int BUF_DEPTH   = 4,      // word buffer entries
    parameter int OUT_CREDITS = 2       // downstream credits
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    pe,           // besm6 compatibility
    input  wire                    word_valid,
    input  wire besm_pkg::word_t   word,
    output logic                   word_credit,
    input  wire                    mod_wr,
    input  wire besm_pkg::modidx_t mod_idx,
    input  wire besm_pkg::eaddr_t  mod_data,
    output logic                   insn_valid,
    output besm_pkg::insn_t        insn,
    input  wire                    insn_credit
);

    logic               head_valid;
    besm_pkg::word_t    head_word;
    logic               pop;
    logic               dec_valid;
    besm_pkg::decoded_t dec;
    logic               dec_ready;

    word_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_word_buffer (
        .clk, .rst_n, .word_valid, .word, .word_credit,
        .head_valid, .head_word, .pop
    );

    decode_stage u_decode_stage (
        .clk, .rst_n, .pe, .head_valid, .head_word, .pop,
        .dec_valid, .dec, .dec_ready
    );

    modifier_stage #(.OUT_CREDITS(OUT_CREDITS)) u_modifier_stage (
        .clk, .rst_n, .dec_valid, .dec, .dec_ready,
        .mod_wr, .mod_idx, .mod_data, .insn_valid, .insn, .insn_credit
    );

endmodule

`default_nettype wire

//--- design/decoder.sv
// instruction half decoder
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire besm_pkg::word_t dc,      // instruction word
    input  wire                  pe,      // besm6 compatibility
    input  wire                  tkk,     // 1 = right half
    output besm_pkg::modidx_t    ir,      // modifier index
    output besm_pkg::opcode_t    op,
    output logic                 extop,   // extended opcode
    output logic                 ir15,    // stack mode
    output besm_pkg::addr_t      addr
);

    besm_pkg::opcode_t base_op;    // opcode before escape check
    besm_pkg::opcode_t next_op;    // byte after base opcode
    logic              long_fmt;   // besm6 format bit
    logic              short_sgn;  // sign of besm6 short address

    assign long_fmt  = tkk ? dc[32] : dc[56];
    assign short_sgn = tkk ? dc[31] : dc[55];
    assign next_op   = tkk ? dc[20:13] : dc[52:45];

    always_comb begin
        if (pe) begin
            // besm6 placement
            if (tkk) begin
                ir = dc[36:33];
                if (long_fmt) begin
                    base_op = {dc[32:28], 3'd0};
                    addr    = {5'd0, dc[27:13]};                   // 15-bit, zero fill
                end else begin
                    base_op = {2'b00, dc[30:25]};
                    addr    = {{8{short_sgn}}, dc[24:13]};         // signed 12-bit
                end
            end else begin
                ir = {dc[64], dc[59:57]};                          // split index field
                if (long_fmt) begin
                    base_op = {dc[56:52], 3'd0};
                    addr    = {5'd0, dc[51:37]};
                end else begin
                    base_op = {2'b00, dc[54:49]};
                    addr    = {{8{short_sgn}}, dc[48:37]};
                end
            end
        end else begin
            // native placement, 32 bits per half
            if (tkk) begin
                ir      = dc[32:29];
                base_op = dc[28:21];
                addr    = dc[20:1];
            end else begin
                ir      = dc[64:61];
                base_op = dc[60:53];
                addr    = dc[52:33];
            end
        end
    end

    // escape only exists in native mode
    assign extop = !pe && (base_op == besm_pkg::EXT_ESCAPE);
    assign op    = extop ? next_op : base_op;
    assign ir15  = (ir == besm_pkg::STACK_MOD);

endmodule

`default_nettype wire

//--- design/modifier_stage.sv
// address modification stage
`timescale 1ns/1ps
`default_nettype none

module modifier_stage #(
    parameter int OUT_CREDITS           // downstream slots after reset
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dec_valid,
    input  wire besm_pkg::decoded_t dec,
    output logic                    dec_ready,
    input  wire                     mod_wr,      // modifier write port
    input  wire besm_pkg::modidx_t  mod_idx,
    input  wire besm_pkg::eaddr_t   mod_data,
    output logic                    insn_valid,
    output besm_pkg::insn_t         insn,
    input  wire                     insn_credit  // one slot freed downstream
);

    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    typedef logic [CRD_W-1:0] credit_t;

    besm_pkg::eaddr_t mods [16];    // modifier file with entry 0 held at zero
    credit_t          credits;      // free downstream slots
    logic             out_valid;    // output register full
    logic             take;         // dec transfer
    besm_pkg::eaddr_t mod_val;
    besm_pkg::eaddr_t eaddr;

    assign take       = dec_valid && dec_ready;
    assign insn_valid = out_valid && (credits != '0);
    assign dec_ready  = !out_valid || insn_valid;   // free or leaving now

    assign mod_val = mods[dec.ir];
    assign eaddr   = dec.addr[14:0] + mod_val;      // wraps modulo 2^15

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                mods[i] <= '0;
            end
        end else begin
            // stack mode post-increment after use
            if (take && dec.ir15)
                mods[besm_pkg::STACK_MOD] <= mods[besm_pkg::STACK_MOD] + 1'b1;
            // port write overrides the increment
            if (mod_wr && (mod_idx != '0))
                mods[mod_idx] <= mod_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            credits   <= credit_t'(OUT_CREDITS);
        end else begin
            out_valid <= take || (out_valid && !insn_valid);
            // send and return may coincide
            credits   <= credits - credit_t'(insn_valid) + credit_t'(insn_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            insn.op    <= dec.op;
            insn.extop <= dec.extop;
            insn.ir    <= dec.ir;
            insn.eaddr <= eaddr;
        end
    end

    // downstream returned more than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= credit_t'(OUT_CREDITS))
        else $error("modifier_stage: credit counter overflow");

endmodule

`default_nettype wire

//--- design/word_buffer.sv
// instruction word buffer
`timescale 1ns/1ps
`default_nettype none

module word_buffer #(
    parameter int BUF_DEPTH             // entries, also upstream credits
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  word_valid,
    input  wire besm_pkg::word_t word,
    output logic                 word_credit,  // one pulse per pop
    output logic                 head_valid,
    output besm_pkg::word_t      head_word,
    input  wire                  pop
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    besm_pkg::word_t mem [BUF_DEPTH];   // payload, no reset
    ptr_t            wr_ptr;
    ptr_t            rd_ptr;
    cnt_t            count;               // words held

    // wrap for depths that are not a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (word_valid)
            mem[wr_ptr] <= word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            word_credit <= 1'b0;
        end else begin
            if (word_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({word_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // idle or push and pop together
            endcase
            word_credit <= pop;                    // credit goes back a cycle after pop
        end
    end

    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];

    // sender pushed without holding a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        word_valid |-> count < cnt_t'(BUF_DEPTH))
        else $error("word_buffer: push into full buffer");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid)
        else $error("word_buffer: pop while empty");

endmodule

`default_nettype wire

//--- sources.f
design/besm_pkg.sv
design/decoder.sv
design/word_buffer.sv
design/decode_stage.sv
design/modifier_stage.sv
design/decode_top.sv
bench/tb_decode_top.sv
